// ==== src.f ====
src/eqv_pkg.sv
src/sol_buffer.sv
src/dup_detector.sv
src/sol_unpacker.sv
src/sol_checker.sv
src/equihash_verifier_top.sv
tb/tb_equihash_verifier.sv

// ==== Bender.yml ====
package:
  name: equihash_verifier

sources:
  - src/eqv_pkg.sv
  - src/sol_buffer.sv
  - src/dup_detector.sv
  - src/sol_unpacker.sv
  - src/sol_checker.sv
  - src/equihash_verifier_top.sv
  - target: test
    files:
      - tb/tb_equihash_verifier.sv

// ==== tb/tb_equihash_verifier.sv ====
// Testbench for the reduced Equihash verifier. Each table row is one packet
// (a seed and eight indices) with an expected mask worked out from the hash
// and ordering rules. The rows are sent in a loop, then mask and timing are checked.
`timescale 1ns/1ns
`default_nettype none

module tb_equihash_verifier;
  import eqv_pkg::*;

  localparam int NUM_ROWS = 15;
  localparam int NUM_HAND = 11;
  localparam int LIMIT    = NUM_ROWS * 40;
  localparam int LATENCY  = 13;

  logic       i_clk;
  logic       i_rst;
  logic [7:0] i_dat;
  logic       i_val;
  logic       i_sop;
  logic       i_eop;
  logic       o_rdy;
  logic [3:0] o_mask;
  logic       o_mask_val;

  logic [15:0] seed_tab [NUM_ROWS];
  logic [11:0] idx_tab  [NUM_ROWS][8];
  logic [3:0]  exp_tab  [NUM_ROWS];

  integer rand_seed   = 32'h0435b467;
  int     cycle       = 0;
  int     checks      = 0;
  int     mismatches  = 0;
  int     other_errs  = 0;
  int     mask_pulses = 0;

  equihash_verifier_top uut (
    .i_clk      ( i_clk      ),
    .i_rst      ( i_rst      ),
    .i_dat      ( i_dat      ),
    .i_val      ( i_val      ),
    .i_sop      ( i_sop      ),
    .i_eop      ( i_eop      ),
    .o_rdy      ( o_rdy      ),
    .o_mask     ( o_mask     ),
    .o_mask_val ( o_mask_val )
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // Cycle count, result pulse count and the run limit
  always @(posedge i_clk) begin
    cycle <= cycle + 1;
    if (!i_rst && o_mask_val === 1'b1)
      mask_pulses <= mask_pulses + 1;
    if (cycle >= LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               checks, mismatches, other_errs);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Upper half is index ^ seed[15:4] and lower half is rotl5(index) ^ seed[11:0]
  function automatic logic [23:0] model_hash(input logic [15:0] seed,
                                             input logic [11:0] idx);
    logic [11:0] rot;
    rot = {idx[6:0], idx[11:7]};
    return {idx ^ seed[15:4], rot ^ seed[11:0]};
  endfunction

  function automatic logic [3:0] expected_mask(input int r);
    logic [23:0] h [8];
    logic [23:0] grp;
    logic [23:0] all_x;
    logic        zero_bad;
    logic        order_bad;
    logic        dup_fnd;
    all_x     = '0;
    zero_bad  = 1'b0;
    order_bad = 1'b0;
    dup_fnd   = 1'b0;
    for (int i = 0; i < 8; i++) begin
      h[i]  = model_hash(seed_tab[r], idx_tab[r][i]);
      all_x = all_x ^ h[i];
    end
    // Groups of 2, 4 and 8 hashes must clear their top 6, 12 and 18 bits
    for (int lvl = 1; lvl <= 3; lvl++) begin
      for (int g = 0; g < 8; g += (1 << lvl)) begin
        grp = '0;
        for (int i = g; i < g + (1 << lvl); i++)
          grp = grp ^ h[i];
        if ((grp >> (N - lvl * COLLISION_BIT_LEN)) != 0)
          zero_bad = 1'b1;
      end
    end
    // The left sibling's first index must be below the right sibling's
    for (int s = 1; s < 8; s = s * 2) begin
      for (int p = s; p < 8; p += 2 * s) begin
        if (idx_tab[r][p - s] >= idx_tab[r][p])
          order_bad = 1'b1;
      end
    end
    for (int i = 0; i < 8; i++) begin
      for (int j = i + 1; j < 8; j++) begin
        if (idx_tab[r][i] == idx_tab[r][j])
          dup_fnd = 1'b1;
      end
    end
    return {|all_x, zero_bad, order_bad, dup_fnd};
  endfunction

  task automatic set_row(input int r, input logic [15:0] seed, input logic [95:0] list);
    seed_tab[r] = seed;
    for (int i = 0; i < 8; i++)
      idx_tab[r][i] = list[95 - 12 * i -: 12];
  endtask

  task automatic load_table;
    logic [95:0] valid;
    logic [95:0] lst;
    // Pairs share their top 6 bits and each quad XORs to zero
    valid = {12'h040, 12'h041, 12'h082, 12'h083, 12'h105, 12'h10C, 12'h1C0, 12'h1C9};
    set_row(0, 16'hA5C3, valid);
    set_row(1, 16'h0000, valid);
    set_row(2, 16'hFFFF, valid);
    // Sibling swaps at levels 1, 2 and 3
    set_row(3, 16'h3C5A, {12'h041, 12'h040, valid[71:0]});
    set_row(4, 16'h3C5A, {12'h082, 12'h083, 12'h040, 12'h041, valid[47:0]});
    set_row(5, 16'h3C5A, {valid[47:0], valid[95:48]});
    // Repeated indices
    set_row(6, 16'h7E11, {valid[95:60], 12'h082, valid[47:0]});
    set_row(7, 16'h7E11, {valid[95:48], valid[95:48]});
    // One low bit and one top bit changed
    set_row(8, 16'hC0DE, {valid[95:12], 12'h1C8});
    set_row(9, 16'hC0DE, {12'h840, valid[83:0]});
    set_row(10, 16'h1234, valid);
    for (int r = NUM_HAND; r < NUM_ROWS; r++) begin
      for (int i = 0; i < 8; i++)
        lst[95 - 12 * i -: 12] = $random(rand_seed);
      set_row(r, $random(rand_seed), lst);
    end
    for (int r = 0; r < NUM_ROWS; r++)
      exp_tab[r] = expected_mask(r);
  endtask

  task automatic next_cycle;
    @(posedge i_clk);
    #1;
  endtask

  // Holds the byte until an edge sees o_rdy high
  task automatic send_byte(input logic [7:0] b, input bit sop, input bit eop, input bit gaps);
    logic rdy_pre;
    int   gap_len;
    if (gaps) begin
      gap_len = $unsigned($random(rand_seed)) % 2;
      i_val   = 1'b0;
      repeat (gap_len) next_cycle();
    end
    i_dat   = b;
    i_val   = 1'b1;
    i_sop   = sop;
    i_eop   = eop;
    rdy_pre = 1'b0;
    while (!rdy_pre) begin
      rdy_pre = o_rdy;
      next_cycle();
    end
    i_val = 1'b0;
    i_sop = 1'b0;
    i_eop = 1'b0;
  endtask

  task automatic send_packet(input int r, input bit gaps, output int eop_cyc);
    logic [95:0] packed_list;
    logic [7:0]  pkt [SOL_BYTS + 2];
    for (int i = 0; i < 8; i++)
      packed_list[95 - 12 * i -: 12] = idx_tab[r][i];
    pkt[0] = seed_tab[r][15:8];
    pkt[1] = seed_tab[r][7:0];
    for (int b = 0; b < SOL_BYTS; b++)
      pkt[b + 2] = packed_list[95 - 8 * b -: 8];
    for (int b = 0; b < SOL_BYTS + 2; b++)
      send_byte(pkt[b], b == 0, b == SOL_BYTS + 1, gaps);
    eop_cyc = cycle;
  endtask

  task automatic check_result(input int r, input int eop_cyc);
    int waited;
    bit seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < 2 * LATENCY) begin
      next_cycle();
      waited++;
      if (o_mask_val === 1'b1)
        seen = 1'b1;
    end
    if (!seen) begin
      $display("Row %0d: no o_mask_val pulse arrived after the packet", r);
      other_errs++;
    end else begin
      checks++;
      if (o_mask !== exp_tab[r]) begin
        $display("Mismatch row %0d: o_mask = 0x%h, expected 0x%h", r, o_mask, exp_tab[r]);
        mismatches++;
      end
      if (cycle - eop_cyc != LATENCY) begin
        $display("Mismatch row %0d: o_mask_val latency = 0x%h, expected 0x%h",
                 r, cycle - eop_cyc, LATENCY);
        mismatches++;
      end
      // The unpacker still holds off new bytes while the result is out
      if (o_rdy !== 1'b0) begin
        $display("Mismatch row %0d: o_rdy = 0x%h, expected 0x0", r, o_rdy);
        mismatches++;
      end
      next_cycle();
      if (o_rdy !== 1'b1) begin
        $display("Mismatch row %0d: o_rdy = 0x%h, expected 0x1", r, o_rdy);
        mismatches++;
      end
      if (o_mask_val !== 1'b0) begin
        $display("Mismatch row %0d: o_mask_val = 0x%h, expected 0x0", r, o_mask_val);
        mismatches++;
      end
    end
  endtask

  initial begin
    int eop_cyc;
    i_rst = 1'b1;
    i_dat = 8'h00;
    i_val = 1'b0;
    i_sop = 1'b0;
    i_eop = 1'b0;
    load_table();
    repeat (5) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    // Every third packet is sent with idle gaps
    for (int r = 0; r < NUM_ROWS; r++) begin
      send_packet(r, (r % 3) == 2, eop_cyc);
      check_result(r, eop_cyc);
    end
    if (mask_pulses != NUM_ROWS) begin
      $display("Saw %0d result pulses for %0d packets", mask_pulses, NUM_ROWS);
      other_errs++;
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/equihash_verifier_top.sv ====
// Top level of the reduced Equihash verifier. Feed one packet per
// result: two seed bytes then twelve packed solution bytes. The mask is
// valid only in the o_mask_val cycle.
`timescale 1ns/1ns
`default_nettype none

module equihash_verifier_top (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire [7:0]               i_dat,
  input  wire                     i_val,
  input  wire                     i_sop,
  input  wire                     i_eop,
  output logic                    o_rdy,
  output eqv_pkg::equihash_mask_t o_mask,
  output logic                    o_mask_val
);
  import eqv_pkg::*;

  localparam int ADDR_W = $clog2(SOL_LIST_LEN);

  logic [SEED_BITS-1:0] seed;
  logic                 wr, rd, list_done, done;
  logic [ADDR_W-1:0]    wr_addr, rd_addr;
  logic [SOL_BITS-1:0]  wr_dat, rd_dat;

  sol_unpacker u_sol_unpacker (
    .i_clk       ( i_clk     ),
    .i_rst       ( i_rst     ),
    .i_dat       ( i_dat     ),
    .i_val       ( i_val     ),
    .i_sop       ( i_sop     ),
    .i_eop       ( i_eop     ),
    .i_done      ( done      ),
    .o_rdy       ( o_rdy     ),
    .o_seed      ( seed      ),
    .o_wr        ( wr        ),
    .o_wr_addr   ( wr_addr   ),
    .o_wr_dat    ( wr_dat    ),
    .o_list_done ( list_done )
  );

  sol_buffer #(
    .SOL_BITS     ( SOL_BITS     ),
    .SOL_LIST_LEN ( SOL_LIST_LEN )
  ) u_sol_buffer (
    .i_clk     ( i_clk   ),
    .i_wr      ( wr      ),
    .i_wr_addr ( wr_addr ),
    .i_wr_dat  ( wr_dat  ),
    .i_rd      ( rd      ),
    .i_rd_addr ( rd_addr ),
    .o_rd_dat  ( rd_dat  )
  );

  sol_checker u_sol_checker (
    .i_clk       ( i_clk      ),
    .i_rst       ( i_rst      ),
    .i_list_done ( list_done  ),
    .i_seed      ( seed       ),
    .i_rd_dat    ( rd_dat     ),
    .o_rd        ( rd         ),
    .o_rd_addr   ( rd_addr    ),
    .o_done      ( done       ),
    .o_mask      ( o_mask     ),
    .o_mask_val  ( o_mask_val )
  );

endmodule

`default_nettype wire

// ==== src/sol_checker.sv ====
// Back end of the verifier. Reads the list back from the buffer, hashes
// each index and checks the XOR tree, the zero ordering per level, the
// sibling index ordering and duplicates. The mask comes twelve cycles
// after the list-done strobe.
`timescale 1ns/1ns
`default_nettype none

module sol_checker (
  input  wire                                      i_clk,
  input  wire                                      i_rst,
  input  wire                                      i_list_done,
  input  wire [eqv_pkg::SEED_BITS-1:0]             i_seed,
  input  wire [eqv_pkg::SOL_BITS-1:0]              i_rd_dat,
  output logic                                     o_rd,
  output logic [$clog2(eqv_pkg::SOL_LIST_LEN)-1:0] o_rd_addr,
  output logic                                     o_done,
  output eqv_pkg::equihash_mask_t                  o_mask,
  output logic                                     o_mask_val
);
  import eqv_pkg::*;

  localparam int ADDR_W = $clog2(SOL_LIST_LEN);

  logic                rd_val, h_val, h_first;
  logic [ADDR_W-1:0]   rd_pos, h_pos;
  logic [SOL_BITS-1:0] h_idx;
  logic [N-1:0]        h_hash;
  // Running XOR of the current group at each tree level
  logic [N-1:0]        lvl_xor [1:K];
  logic [N-1:0]        lvl_nxt [1:K];
  // First index of the current group at each level
  logic [SOL_BITS-1:0] first_idx [1:K];
  logic                zero_err, order_err;
  logic                bad_zero, bad_idx;
  logic                dup_val, dup;

  always_comb begin
    h_first = h_val && h_pos == '0;
    zero_err  = 1'b0;
    order_err = 1'b0;
    for (int h = 1; h <= K; h++) begin
      if (int'(h_pos) % (1 << h) == 0)
        lvl_nxt[h] = h_hash;
      else
        lvl_nxt[h] = lvl_xor[h] ^ h_hash;
      // At a group end the top h collision slices must have cancelled
      if (int'(h_pos) % (1 << h) == (1 << h) - 1 &&
          (lvl_nxt[h] >> (N - h * COLLISION_BIT_LEN)) != '0)
        zero_err = 1'b1;
    end
    // Start of a right sibling, compare with the left sibling's first index
    for (int l = 0; l < K; l++) begin
      if (int'(h_pos) % (1 << (l + 1)) == (1 << l) && first_idx[l + 1] >= h_idx)
        order_err = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rd       <= 1'b0;
      o_rd_addr  <= '0;
      rd_val     <= 1'b0;
      h_val      <= 1'b0;
      bad_zero   <= 1'b0;
      bad_idx    <= 1'b0;
      o_mask_val <= 1'b0;
      o_done     <= 1'b0;
    end else begin
      rd_val     <= o_rd;
      h_val      <= rd_val;
      // The duplicate verdict lands in the cycle after the last hash update
      o_mask_val <= dup_val;
      o_done     <= dup_val;
      if (i_list_done) begin
        o_rd      <= 1'b1;
        o_rd_addr <= '0;
        bad_zero  <= 1'b0;
        bad_idx   <= 1'b0;
      end else if (o_rd) begin
        if (o_rd_addr == ADDR_W'(SOL_LIST_LEN - 1))
          o_rd <= 1'b0;
        else
          o_rd_addr <= o_rd_addr + 1'b1;
      end
      if (h_val) begin
        bad_zero <= bad_zero | zero_err;
        bad_idx  <= bad_idx | order_err;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    rd_pos <= o_rd_addr;
    h_pos  <= rd_pos;
    h_idx  <= i_rd_dat;
    h_hash <= index_hash(i_seed, i_rd_dat);
    if (h_val) begin
      for (int h = 1; h <= K; h++) begin
        lvl_xor[h] <= lvl_nxt[h];
        if (int'(h_pos) % (1 << h) == 0)
          first_idx[h] <= h_idx;
      end
    end
    if (dup_val) begin
      o_mask.xor_non_zero   <= |lvl_xor[K];
      o_mask.bad_zero_order <= bad_zero;
      o_mask.bad_idx_order  <= bad_idx;
      o_mask.duplicate_fnd  <= dup;
    end
  end

  dup_detector #(
    .SOL_BITS     ( SOL_BITS     ),
    .SOL_LIST_LEN ( SOL_LIST_LEN )
  ) u_dup_detector (
    .i_clk     ( i_clk   ),
    .i_rst     ( i_rst   ),
    .i_val     ( h_val   ),
    .i_first   ( h_first ),
    .i_idx     ( h_idx   ),
    .o_dup_val ( dup_val ),
    .o_dup     ( dup     )
  );

endmodule

`default_nettype wire

// ==== src/sol_unpacker.sv ====
// Front end of the verifier. Takes the packet byte stream, keeps the
// seed and cuts the MSB-first packed indices into buffer writes.
// After the last index it waits for the checker before taking more.
`timescale 1ns/1ns
`default_nettype none

module sol_unpacker (
  input  wire                                      i_clk,
  input  wire                                      i_rst,
  input  wire [7:0]                                i_dat,
  input  wire                                      i_val,
  input  wire                                      i_sop,
  input  wire                                      i_eop,
  input  wire                                      i_done,
  output logic                                     o_rdy,
  output logic [eqv_pkg::SEED_BITS-1:0]            o_seed,
  output logic                                     o_wr,
  output logic [$clog2(eqv_pkg::SOL_LIST_LEN)-1:0] o_wr_addr,
  output logic [eqv_pkg::SOL_BITS-1:0]             o_wr_dat,
  output logic                                     o_list_done
);
  import eqv_pkg::*;

  localparam int SEED_BYTS = SEED_BITS / 8;
  localparam int BYTE_W    = $clog2(SEED_BYTS + SOL_BYTS + 1);
  localparam int ADDR_W    = $clog2(SOL_LIST_LEN);
  localparam int ACC_W     = SOL_BITS + 8;

  typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_WAIT} state_t;

  state_t            state;
  logic [BYTE_W-1:0] byte_cnt;
  logic [ACC_W-1:0]  acc, acc_nxt;
  logic [4:0]        acc_bits, bits_nxt;
  logic [ADDR_W-1:0] idx_cnt;
  logic              take, seed_byte, sol_byte, emit;

  always_comb begin
    take      = i_val && o_rdy;
    seed_byte = take && ((state == ST_IDLE && i_sop) ||
                         (state == ST_DATA && byte_cnt < SEED_BYTS));
    sol_byte  = take && state == ST_DATA && byte_cnt >= SEED_BYTS &&
                byte_cnt < SEED_BYTS + SOL_BYTS;
    acc_nxt   = (acc << 8) | ACC_W'(i_dat);
    bits_nxt  = acc_bits + 5'd8;
    // An index is ready once twelve or more bits sit in the accumulator
    emit      = sol_byte && bits_nxt >= SOL_BITS;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= ST_IDLE;
      o_rdy       <= 1'b0;
      byte_cnt    <= '0;
      acc_bits    <= '0;
      idx_cnt     <= '0;
      o_wr        <= 1'b0;
      o_list_done <= 1'b0;
    end else begin
      o_wr        <= emit;
      o_list_done <= o_wr && o_wr_addr == ADDR_W'(SOL_LIST_LEN - 1);
      if (sol_byte)
        acc_bits <= emit ? bits_nxt - 5'(SOL_BITS) : bits_nxt;
      if (emit)
        idx_cnt <= idx_cnt + 1'b1;
      case (state)
        ST_IDLE: begin
          o_rdy <= 1'b1;
          if (take && i_sop) begin
            byte_cnt <= BYTE_W'(1);
            acc_bits <= '0;
            idx_cnt  <= '0;
            state    <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (take) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (i_eop) begin
              o_rdy <= 1'b0;
              state <= ST_WAIT;
            end
          end
        end
        default: begin
          // Hold the seed and the buffer until the result is out
          if (i_done) begin
            o_rdy <= 1'b1;
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (seed_byte)
      o_seed <= {o_seed[SEED_BITS-9:0], i_dat};
    if (sol_byte)
      acc <= acc_nxt;
    if (emit) begin
      o_wr_dat  <= acc_nxt[bits_nxt - SOL_BITS +: SOL_BITS];
      o_wr_addr <= idx_cnt;
    end
  end

endmodule

`default_nettype wire

// ==== src/dup_detector.sv ====
// Flags a repeated index within one list. Each index is compared with
// every earlier one; the verdict comes one cycle after the last index.
`timescale 1ns/1ns
`default_nettype none

module dup_detector #(
  parameter int SOL_BITS     = 12,
  parameter int SOL_LIST_LEN = 8
)(
  input  wire                i_clk,
  input  wire                i_rst,
  input  wire                i_val,
  input  wire                i_first,
  input  wire [SOL_BITS-1:0] i_idx,
  output logic               o_dup_val,
  output logic               o_dup
);

  localparam int PTR_W = (SOL_LIST_LEN > 1) ? $clog2(SOL_LIST_LEN) : 1;

  logic [SOL_BITS-1:0]     seen [SOL_LIST_LEN];
  logic [SOL_LIST_LEN-1:0] seen_vld, vld_nxt;
  logic [PTR_W-1:0]        cnt, ptr;
  logic                    dup_flag, hit, dup_nxt;

  always_comb begin
    // A first strobe restarts the list at entry 0
    ptr     = i_first ? '0 : cnt;
    vld_nxt = i_first ? '0 : seen_vld;
    vld_nxt[ptr] = 1'b1;
    hit     = 1'b0;
    for (int i = 0; i < SOL_LIST_LEN; i++) begin
      if (!i_first && seen_vld[i] && seen[i] == i_idx)
        hit = 1'b1;
    end
    dup_nxt = hit || (dup_flag && !i_first);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      seen_vld  <= '0;
      cnt       <= '0;
      dup_flag  <= 1'b0;
      o_dup_val <= 1'b0;
      o_dup     <= 1'b0;
    end else begin
      o_dup_val <= 1'b0;
      if (i_val) begin
        seen_vld <= vld_nxt;
        cnt      <= ptr + 1'b1;
        dup_flag <= dup_nxt;
        if (ptr == PTR_W'(SOL_LIST_LEN - 1)) begin
          o_dup_val <= 1'b1;
          o_dup     <= dup_nxt;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_val)
      seen[ptr] <= i_idx;
  end

endmodule

`default_nettype wire

// ==== src/sol_buffer.sv ====
// Holds the indices of one solution list between unpacker and checker.
// One write port and one registered read port, data one cycle after
// the read enable.
`timescale 1ns/1ns
`default_nettype none

module sol_buffer #(
  parameter int SOL_BITS     = 12,
  parameter int SOL_LIST_LEN = 8
)(
  input  wire                            i_clk,
  input  wire                            i_wr,
  input  wire [$clog2(SOL_LIST_LEN)-1:0] i_wr_addr,
  input  wire [SOL_BITS-1:0]             i_wr_dat,
  input  wire                            i_rd,
  input  wire [$clog2(SOL_LIST_LEN)-1:0] i_rd_addr,
  output logic [SOL_BITS-1:0]            o_rd_dat
);

  logic [SOL_BITS-1:0] mem [SOL_LIST_LEN];

  // Write side, driven by the unpacker
  always_ff @(posedge i_clk) begin
    if (i_wr)
      mem[i_wr_addr] <= i_wr_dat;
  end

  // Read side, driven by the checker
  always_ff @(posedge i_clk) begin
    if (i_rd)
      o_rd_dat <= mem[i_rd_addr];
  end

endmodule

`default_nettype wire

// ==== src/eqv_pkg.sv ====
// Shared definitions for the reduced Equihash solution verifier.
// Holds the list and hash sizes, the four-flag result mask and the
// index_hash generator that stands in for the full digest.
`default_nettype none

package eqv_pkg;

  localparam int SOL_BITS          = 12;
  localparam int K                 = 3;
  localparam int SOL_LIST_LEN      = 1 << K;
  localparam int N                 = 24;
  localparam int COLLISION_BIT_LEN = N / (K + 1);
  localparam int SEED_BITS         = 16;
  localparam int SOL_BYTS          = SOL_LIST_LEN * SOL_BITS / 8;

  // Result flags, most significant first
  typedef struct packed {
    logic xor_non_zero;
    logic bad_zero_order;
    logic bad_idx_order;
    logic duplicate_fnd;
  } equihash_mask_t;

  // The hash is linear in the index, so any XOR over an even number
  // of hashes loses the seed completely
  function automatic logic [N-1:0] index_hash(
    input logic [SEED_BITS-1:0] seed,
    input logic [SOL_BITS-1:0]  idx
  );
    logic [SOL_BITS-1:0] rot;
    // Rotate left by 5 within the index width
    rot = {idx[SOL_BITS-6:0], idx[SOL_BITS-1 -: 5]};
    return {idx ^ seed[SEED_BITS-1 -: SOL_BITS], rot ^ seed[SOL_BITS-1:0]};
  endfunction

endpackage

`default_nettype wire
